//--- hw/pcie_phy_pkg.sv
`default_nettype none

package pcie_phy_pkg;

  // One PIPE symbol
  typedef logic [7:0] data_t;

  // Gen3 scrambler LFSR width
  localparam int LFSR_W = 24;

  // Per-lane scrambler seeds, indexed by lane number modulo eight
  localparam logic [LFSR_W-1:0] gen3_seed_values [8] = '{
    24'h1DBFBC,
    24'h0607BB,
    24'h1EC760,
    24'h18C0DB,
    24'h010F12,
    24'h19CFC9,
    24'h0277CE,
    24'h1BB807
  };

  // Gen3 SKP symbol
  localparam data_t GEN3_SKP = 8'hAA;

  // Symbol 0 identifiers of the training sets
  localparam data_t TS1OS = 8'h1E;
  localparam data_t TS2OS = 8'h2D;

  // Low two symbols of an EIEOS word
  localparam logic [15:0] EIEOS_PATTERN = 16'h00FF;

  // Low two symbols of a SKP word
  localparam logic [15:0] SKP_PATTERN = {GEN3_SKP, 8'h1E};

  // 128b/130b sync header codes
  typedef enum logic [1:0] {
    SH_DATA = 2'b01,
    SH_OS   = 2'b10
  } sync_hdr_e;

  // Classification of the block currently on the lane
  typedef enum logic [2:0] {
    BK_DATA,
    BK_OS,
    BK_TS,
    BK_EIEOS,
    BK_SKP
  } block_kind_e;

endpackage

`default_nettype wire

//--- hw/gen3_byte_scramble.sv
`default_nettype none

module gen3_byte_scramble
  import pcie_phy_pkg::*;
(
  input  logic              disable_lfsr_advance_i,
  input  logic [LFSR_W-1:0] lfsr_i,
  output logic [LFSR_W-1:0] lfsr_o
);

  // Feedback taps for x^23+x^21+x^16+x^8+x^5+x^2+1, bits 21,16,8,5,2,0
  localparam logic [LFSR_W-1:0] LFSR_TAPS = 24'h210125;

  // Working copy of the state across the eight shifts
  logic [LFSR_W-1:0] state;

  always_comb begin
    state = lfsr_i;
    // SKP holds the state for the whole symbol
    if (!disable_lfsr_advance_i) begin
      for (int i = 0; i < 8; i++) begin
        // Top bit feeds back into every tap on its way out
        if (state[LFSR_W-1]) begin
          state = {state[LFSR_W-2:0], 1'b0} ^ LFSR_TAPS;
        end else begin
          state = {state[LFSR_W-2:0], 1'b0};
        end
      end
    end
    lfsr_o = state;
  end

endmodule

`default_nettype wire

//--- hw/gen3_scramble.sv
`default_nettype none

module gen3_scramble
  import pcie_phy_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [7:0]  lane_number_i,
  input  logic [5:0]  pipe_width_i,
  input  sync_hdr_e   sync_header_i,
  input  logic [31:0] data_in_i,
  input  logic [3:0]  data_k_in_i,
  input  logic        data_valid_i,
  output logic        data_valid_o,
  output logic [31:0] data_out_o,
  output logic [3:0]  data_k_out_o
);

  // Current LFSR state and its next value
  logic [LFSR_W-1:0] lfsr_r;
  logic [LFSR_W-1:0] lfsr_c;
  // Seed of this lane
  logic [LFSR_W-1:0] seed;
  // State after 0 to 4 symbol advances
  logic [LFSR_W-1:0] lfsr_st [5];
  // Scramble byte applied to each symbol position
  data_t             scr_byte [4];
  // Live symbols per word
  logic [2:0]        byte_cnt;
  // Block classification, registered and for the current word
  block_kind_e       kind_r;
  block_kind_e       kind_c;
  // Pattern matches on the incoming word
  logic              eieos_match;
  logic              skp_match;
  logic              ts_match;
  // Bypass decisions for the current word
  logic              eieos_word;
  logic              skp_word;
  logic              ts_bypass;
  // Scrambled word before the output register
  logic [31:0]       data_c;

  assign seed = gen3_seed_values[lane_number_i[2:0]];

  // PIPE width in symbols
  always_comb begin
    case (pipe_width_i)
      6'd8:    byte_cnt = 3'd1;
      6'd16:   byte_cnt = 3'd2;
      default: byte_cnt = 3'd4;
    endcase
  end

  // Ordered set patterns are checked on the low two symbols
  assign eieos_match = (data_in_i[15:0] == EIEOS_PATTERN);
  assign skp_match   = (data_in_i[15:0] == SKP_PATTERN);
  assign ts_match    = (data_in_i[7:0] == TS1OS) || (data_in_i[7:0] == TS2OS);

  // Words without a valid sync header continue the current block
  always_comb begin
    kind_c = kind_r;
    if (data_valid_i) begin
      case (sync_header_i)
        SH_DATA: begin
          kind_c = BK_DATA;
        end
        SH_OS: begin
          // SKP checked ahead of TS since its symbol 0 also reads 1E
          if (eieos_match) begin
            kind_c = BK_EIEOS;
          end else if (skp_match) begin
            kind_c = BK_SKP;
          end else if (ts_match) begin
            kind_c = BK_TS;
          end else begin
            kind_c = BK_OS;
          end
        end
        default: begin
          kind_c = kind_r;
        end
      endcase
    end
  end

  assign eieos_word = data_valid_i && (kind_c == BK_EIEOS);
  assign skp_word   = data_valid_i && (kind_c == BK_SKP);
  // Only symbol 0 of the first TS word, and only on lane 0
  assign ts_bypass  = data_valid_i && (kind_c == BK_TS) && (sync_header_i == SH_OS)
                      && (lane_number_i == 8'd0);

  // Four symbol advances in a chain, all held on a SKP word
  assign lfsr_st[0] = lfsr_r;

  for (genvar k = 0; k < 4; k++) begin : g_byte
    gen3_byte_scramble u_byte_scramble (
      .disable_lfsr_advance_i (skp_word),
      .lfsr_i                 (lfsr_st[k]),
      .lfsr_o                 (lfsr_st[k+1])
    );
    // Top eight bits reversed, bit 23 lands on bit 0
    assign scr_byte[k] = {<<{lfsr_st[k][LFSR_W-1 -: 8]}};
  end

  // Live symbols are scrambled unless bypassed; inactive ones pass
  always_comb begin
    data_c = data_in_i;
    for (int k = 0; k < 4; k++) begin
      if ((k < byte_cnt) && !eieos_word && !skp_word && !(ts_bypass && (k == 0))) begin
        data_c[8*k +: 8] = data_in_i[8*k +: 8] ^ scr_byte[k];
      end
    end
  end

  // Bypassed symbols still advance; EIEOS reseeds after the word
  always_comb begin
    lfsr_c = lfsr_r;
    if (data_valid_i) begin
      if (eieos_word) begin
        lfsr_c = seed;
      end else begin
        case (byte_cnt)
          3'd1:    lfsr_c = lfsr_st[1];
          3'd2:    lfsr_c = lfsr_st[2];
          default: lfsr_c = lfsr_st[4];
        endcase
      end
    end
  end

  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_r       <= seed;
      kind_r       <= BK_DATA;
      data_valid_o <= 1'b0;
    end else begin
      lfsr_r       <= lfsr_c;
      kind_r       <= kind_c;
      data_valid_o <= data_valid_i;
    end
  end

  // Payload register with the K flags carried alongside unchanged
  always_ff @(posedge clk_i) begin
    if (data_valid_i) begin
      data_out_o   <= data_c;
      data_k_out_o <= data_k_in_i;
    end
  end

endmodule

`default_nettype wire

//--- hw/gen3_tx_ingress.sv
`default_nettype none

module gen3_tx_ingress #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        in_valid_i,
  input  logic [31:0] in_data_i,
  input  logic [3:0]  in_k_i,
  input  logic [1:0]  in_sync_header_i,
  output logic        in_credit_o,
  input  logic        room_i,
  output logic        out_valid_o,
  output logic [31:0] out_data_o,
  output logic [3:0]  out_k_o,
  output logic [1:0]  out_sync_header_o
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // Word storage
  logic [31:0]      data_mem [FIFO_DEPTH];
  logic [3:0]       k_mem    [FIFO_DEPTH];
  logic [1:0]       sh_mem   [FIFO_DEPTH];
  // Circular pointers and occupancy
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop;

  // Wrap also for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Pop when a word waits and the egress has a slot for it
  assign pop = (count != '0) && room_i;

  // Head word goes straight to the scrambler
  assign out_valid_o       = pop;
  assign out_data_o        = data_mem[rd_ptr];
  assign out_k_o           = k_mem[rd_ptr];
  assign out_sync_header_o = sh_mem[rd_ptr];

  // Each freed slot goes back upstream as a credit
  assign in_credit_o = pop;

  // Upstream credits guarantee a free slot on every push
  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      data_mem[wr_ptr] <= in_data_i;
      k_mem[wr_ptr]    <= in_k_i;
      sh_mem[wr_ptr]   <= in_sync_header_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({in_valid_i, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/gen3_tx_egress.sv
`default_nettype none

module gen3_tx_egress #(
  parameter int FIFO_DEPTH   = 4,
  parameter int DOWN_CREDITS = 4
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic        in_valid_i,
  input  logic [31:0] in_data_i,
  input  logic [3:0]  in_k_i,
  output logic        room_o,
  output logic        out_valid_o,
  output logic [31:0] out_data_o,
  output logic [3:0]  out_k_o,
  input  logic        out_credit_i
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int CRD_W = $clog2(DOWN_CREDITS + 1);

  // Word storage
  logic [31:0]      data_mem [FIFO_DEPTH];
  logic [3:0]       k_mem    [FIFO_DEPTH];
  // Circular pointers and occupancy
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_slots;
  // Credits held for the downstream consumer
  logic [CRD_W-1:0] credits;
  logic             send;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign free_slots = CNT_W'(FIFO_DEPTH) - count;

  // A valid scrambler output already owns one slot
  // Room only while another word fits behind it
  assign room_o = free_slots > CNT_W'(in_valid_i);

  // Head leaves only while a downstream credit is held
  assign send        = (count != '0) && (credits != '0);
  assign out_valid_o = send;
  assign out_data_o  = data_mem[rd_ptr];
  assign out_k_o     = k_mem[rd_ptr];

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      data_mem[wr_ptr] <= in_data_i;
      k_mem[wr_ptr]    <= in_k_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= CRD_W'(DOWN_CREDITS);
    end else begin
      if (in_valid_i) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (send) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({in_valid_i, send})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Returned credit and a send in the same cycle cancel out
      case ({out_credit_i, send})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/gen3_tx_lane.sv
`default_nettype none

module gen3_tx_lane
  import pcie_phy_pkg::*;
#(
  parameter int FIFO_DEPTH   = 4,
  parameter int DOWN_CREDITS = 4
) (
  input  logic        clk_i,
  input  logic        rst_i,
  input  logic [7:0]  lane_number_i,
  input  logic [5:0]  pipe_width_i,
  input  logic        in_valid_i,
  input  logic [31:0] in_data_i,
  input  logic [3:0]  in_k_i,
  input  logic [1:0]  in_sync_header_i,
  output logic        in_credit_o,
  output logic        out_valid_o,
  output logic [31:0] out_data_o,
  output logic [3:0]  out_k_o,
  input  logic        out_credit_i
);

  // Ingress to scrambler
  logic        ing_valid;
  logic [31:0] ing_data;
  logic [3:0]  ing_k;
  logic [1:0]  ing_sync_header;
  // Scrambler to egress
  logic        scr_valid;
  logic [31:0] scr_data;
  logic [3:0]  scr_k;
  // Egress slot report back to the ingress
  logic        egr_room;

  gen3_tx_ingress #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_ingress (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .in_valid_i        (in_valid_i),
    .in_data_i         (in_data_i),
    .in_k_i            (in_k_i),
    .in_sync_header_i  (in_sync_header_i),
    .in_credit_o       (in_credit_o),
    .room_i            (egr_room),
    .out_valid_o       (ing_valid),
    .out_data_o        (ing_data),
    .out_k_o           (ing_k),
    .out_sync_header_o (ing_sync_header)
  );

  gen3_scramble u_scramble (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .lane_number_i (lane_number_i),
    .pipe_width_i  (pipe_width_i),
    .sync_header_i (sync_hdr_e'(ing_sync_header)),
    .data_in_i     (ing_data),
    .data_k_in_i   (ing_k),
    .data_valid_i  (ing_valid),
    .data_valid_o  (scr_valid),
    .data_out_o    (scr_data),
    .data_k_out_o  (scr_k)
  );

  gen3_tx_egress #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .DOWN_CREDITS (DOWN_CREDITS)
  ) u_egress (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_valid_i   (scr_valid),
    .in_data_i    (scr_data),
    .in_k_i       (scr_k),
    .room_o       (egr_room),
    .out_valid_o  (out_valid_o),
    .out_data_o   (out_data_o),
    .out_k_o      (out_k_o),
    .out_credit_i (out_credit_i)
  );

endmodule

`default_nettype wire

//--- tb/gen3_tx_lane_sva.sv
`default_nettype none

module gen3_tx_lane_sva #(
  parameter int FIFO_DEPTH   = 4,
  parameter int DOWN_CREDITS = 4
) (
  input logic clk_i,
  input logic rst_i,
  input logic in_valid_i,
  input logic in_credit_o,
  input logic out_valid_o,
  input logic out_credit_i
);

  // Credits the upstream sender holds
  int up_cnt;
  // Credits the lane holds for the downstream consumer
  int dn_cnt;
  // Failed assertions, read back by the testbench
  int assert_fails = 0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      up_cnt <= FIFO_DEPTH;
      dn_cnt <= DOWN_CREDITS;
    end else begin
      up_cnt <= up_cnt - int'(in_valid_i) + int'(in_credit_o);
      dn_cnt <= dn_cnt - int'(out_valid_o) + int'(out_credit_i);
    end
  end

  up_send_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    in_valid_i |-> (up_cnt > 0))
    else begin
      $error("upstream word sent while no credit was held");
      assert_fails++;
    end

  down_send_has_credit: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o |-> (dn_cnt > 0))
    else begin
      $error("downstream word sent while no credit was held");
      assert_fails++;
    end

  // Egress comes out of reset empty
  quiet_after_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
    else begin
      $error("out_valid_o high in the cycle after reset");
      assert_fails++;
    end

endmodule

bind gen3_tx_lane gen3_tx_lane_sva #(
  .FIFO_DEPTH   (FIFO_DEPTH),
  .DOWN_CREDITS (DOWN_CREDITS)
) u_sva (.*);

`default_nettype wire

//--- tb/gen3_tx_lane_tb.sv
`default_nettype none

module gen3_tx_lane_tb
  import pcie_phy_pkg::*;
();

  localparam int FIFO_DEPTH   = 4;
  localparam int DOWN_CREDITS = 4;
  localparam int TIMEOUT      = 2000;

  // Gen3 per-lane seed table
  localparam logic [23:0] SEEDS [8] = '{24'h1DBFBC, 24'h0607BB, 24'h1EC760, 24'h18C0DB,
                                        24'h010F12, 24'h19CFC9, 24'h0277CE, 24'h1BB807};
  // Galois taps of x^23+x^21+x^16+x^8+x^5+x^2+1
  localparam logic [23:0] POLY_TAPS =
    24'((1 << 21) | (1 << 16) | (1 << 8) | (1 << 5) | (1 << 2) | 1);

  logic        clk_i;
  logic        rst_i;
  logic [7:0]  lane_number_i;
  logic [5:0]  pipe_width_i;
  logic        in_valid_i;
  logic [31:0] in_data_i;
  logic [3:0]  in_k_i;
  logic [1:0]  in_sync_header_i;
  logic        in_credit_o;
  logic        out_valid_o;
  logic [31:0] out_data_o;
  logic [3:0]  out_k_o;
  logic        out_credit_i;

  // Reference scrambler state
  logic [23:0] ref_lfsr;
  int          ref_lane;
  int          ref_width;
  // Expected words in send order
  logic [31:0] exp_data [$];
  logic [3:0]  exp_k [$];
  // Handshake bookkeeping
  int          up_credits;
  int          credit_pulses;
  int          words_sent;
  int          owed;
  bit          withhold;
  // Result counters
  int          errors;
  int          test_start;
  int          tests_run;
  int          tests_failed;
  int          words_checked;

  gen3_tx_lane #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .DOWN_CREDITS (DOWN_CREDITS)
  ) dut0 (.*);

  always #5 clk_i = ~clk_i;

  // Eight serial shifts of the Galois LFSR
  function automatic logic [23:0] lfsr_step(input logic [23:0] s);
    logic [23:0] n;
    n = s;
    for (int i = 0; i < 8; i++) begin
      n = {n[22:0], 1'b0} ^ ({24{n[23]}} & POLY_TAPS);
    end
    return n;
  endfunction

  // Bit 23 of the state becomes bit 0 of the scramble byte
  function automatic logic [7:0] key_byte(input logic [23:0] s);
    logic [7:0] b;
    for (int i = 0; i < 8; i++) begin
      b[i] = s[23 - i];
    end
    return b;
  endfunction

  function automatic logic [31:0] scramble_ref(input logic [31:0] d, input logic [1:0] sh);
    logic [31:0] r;
    logic [23:0] s;
    bit          eieos;
    bit          skp;
    bit          ts;
    r     = d;
    s     = ref_lfsr;
    eieos = (sh == SH_OS) && (d[15:0] == 16'h00FF);
    skp   = (sh == SH_OS) && (d[15:8] == GEN3_SKP) && (d[7:0] == 8'h1E);
    ts    = (sh == SH_OS) && !skp && ((d[7:0] == TS1OS) || (d[7:0] == TS2OS));
    // SKP leaves data and LFSR untouched
    if (skp) begin
      return d;
    end
    for (int k = 0; k < ref_width / 8; k++) begin
      if (!eieos && !(ts && (k == 0) && (ref_lane == 0))) begin
        r[8*k +: 8] = d[8*k +: 8] ^ key_byte(s);
      end
      s = lfsr_step(s);
    end
    ref_lfsr = eieos ? SEEDS[ref_lane % 8] : s;
    return r;
  endfunction

  // Downstream consumer hands credits back after random delays
  always @(negedge clk_i) begin
    out_credit_i = 1'b0;
    if (!rst_i && !withhold && (owed > 0) && ($urandom_range(3) == 0)) begin
      out_credit_i = 1'b1;
      owed--;
    end
  end

  always @(posedge clk_i) begin : compare_out
    logic [31:0] want_data;
    logic [3:0]  want_k;
    if (!rst_i && in_credit_o) begin
      up_credits++;
      credit_pulses++;
    end
    if (!rst_i && out_valid_o) begin
      owed++;
      if (exp_data.size() == 0) begin
        $display("[FAIL] %0t: unexpected output word %h", $time, out_data_o);
        errors++;
      end else begin
        want_data = exp_data.pop_front();
        want_k    = exp_k.pop_front();
        words_checked++;
        if (out_data_o !== want_data) begin
          $display("[FAIL] %0t: data %h, expected %h", $time, out_data_o, want_data);
          errors++;
        end
        if (out_k_o !== want_k) begin
          $display("[FAIL] %0t: K flags %b, expected %b", $time, out_k_o, want_k);
          errors++;
        end
      end
    end
  end

  // Called on a falling edge, returns two cycles later with the lane reset
  task automatic reset_dut(input int lane, input int width);
    in_valid_i    = 1'b0;
    lane_number_i = 8'(lane);
    pipe_width_i  = 6'(width);
    rst_i         = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_i         = 1'b0;
    ref_lane      = lane;
    ref_width     = width;
    ref_lfsr      = SEEDS[lane % 8];
    up_credits    = FIFO_DEPTH;
    owed          = 0;
    credit_pulses = 0;
    words_sent    = 0;
  endtask

  task automatic send_word(input logic [31:0] data, input logic [3:0] k, input logic [1:0] sh);
    int waited;
    waited = 0;
    while ((up_credits == 0) && (waited < TIMEOUT)) begin
      in_valid_i = 1'b0;
      @(negedge clk_i);
      waited++;
    end
    if (up_credits == 0) begin
      $display("Timeout: no upstream credit came back within %0d cycles", TIMEOUT);
      errors++;
    end else begin
      in_valid_i       = 1'b1;
      in_data_i        = data;
      in_k_i           = k;
      in_sync_header_i = sh;
      exp_data.push_back(scramble_ref(data, sh));
      exp_k.push_back(k);
      up_credits--;
      words_sent++;
      @(negedge clk_i);
    end
  endtask

  task automatic finish_test(input string name);
    int waited;
    in_valid_i = 1'b0;
    waited     = 0;
    while ((exp_data.size() != 0) && (waited < TIMEOUT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_data.size() != 0) begin
      $display("Timeout: %0d words never left the lane in %s", exp_data.size(), name);
      errors++;
    end
    // Every popped word frees one ingress slot
    if (credit_pulses != words_sent) begin
      $display("[FAIL] %0t: %0d credits for %0d words", $time, credit_pulses, words_sent);
      errors++;
    end
    tests_run++;
    if (errors == test_start) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: FAIL, %0d errors", name, errors - test_start);
      tests_failed++;
    end
    test_start = errors;
  endtask

  initial begin
    void'($urandom(32'h74f42f5e));
    clk_i            = 1'b0;
    rst_i            = 1'b1;
    lane_number_i    = 8'd0;
    pipe_width_i     = 6'd32;
    in_valid_i       = 1'b0;
    in_data_i        = '0;
    in_k_i           = '0;
    in_sync_header_i = SH_DATA;
    out_credit_i     = 1'b0;
    withhold         = 1'b0;
    owed             = 0;
    errors           = 0;
    test_start       = 0;
    tests_run        = 0;
    tests_failed     = 0;
    words_checked    = 0;

    reset_dut(0, 32);
    repeat (16) send_word($urandom(), 4'($urandom()), SH_DATA);
    finish_test("data blocks, width 32, lane 0");

    // Data after EIEOS restarts from the seed
    reset_dut(0, 32);
    repeat (3) send_word($urandom(), 4'($urandom()), SH_DATA);
    send_word({EIEOS_PATTERN, EIEOS_PATTERN}, 4'h0, SH_OS);
    repeat (4) send_word($urandom(), 4'($urandom()), SH_DATA);
    finish_test("EIEOS reseed");

    reset_dut(0, 32);
    repeat (3) send_word($urandom(), 4'($urandom()), SH_DATA);
    send_word({GEN3_SKP, GEN3_SKP, SKP_PATTERN}, 4'h0, SH_OS);
    repeat (4) send_word($urandom(), 4'($urandom()), SH_DATA);
    finish_test("SKP holds LFSR");

    // Symbol 0 bypasses on lane 0 and is scrambled on lane 3
    for (int lane = 0; lane < 4; lane += 3) begin
      reset_dut(lane, 32);
      send_word({16'($urandom()), 8'h4A, TS1OS}, 4'h1, SH_OS);
      send_word({16'($urandom()), 8'h4A, TS2OS}, 4'h1, SH_OS);
      send_word({16'($urandom()), 8'h4A, 8'h55}, 4'h1, SH_OS);
      repeat (3) send_word($urandom(), 4'($urandom()), SH_DATA);
      finish_test($sformatf("TS1 and TS2 symbol 0, lane %0d", lane));
    end

    for (int width = 8; width <= 16; width += 8) begin
      reset_dut(0, width);
      repeat (10) send_word($urandom(), 4'($urandom()), SH_DATA);
      finish_test($sformatf("data blocks, width %0d", width));
    end

    // Long stretches without downstream credits
    reset_dut(0, 32);
    fork
      begin
        repeat (24) send_word($urandom(), 4'($urandom()), SH_DATA);
        in_valid_i = 1'b0;
      end
      repeat (4) begin
        withhold = 1'b1;
        repeat (60) @(negedge clk_i);
        withhold = 1'b0;
        repeat (8) @(negedge clk_i);
      end
    join
    finish_test("back-pressure");

    errors += dut0.u_sva.assert_fails;
    $display("Tests: %0d run, %0d failed; words checked: %0d; errors: %0d",
             tests_run, tests_failed, words_checked, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- gen3_tx_lane.f
hw/pcie_phy_pkg.sv
hw/gen3_byte_scramble.sv
hw/gen3_scramble.sv
hw/gen3_tx_ingress.sv
hw/gen3_tx_egress.sv
hw/gen3_tx_lane.sv
tb/gen3_tx_lane_sva.sv
tb/gen3_tx_lane_tb.sv
